// File: filelist.f
hdl/fetch_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/branch_predict.sv
hdl/pc_gen.sv
hdl/fetch_queue.sv
hdl/frontend_top.sv
verif/imem_model.sv
verif/tb_frontend.sv

// File: hdl/bht.sv
`timescale 1ns/100ps

module bht (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_bp_i,
    input  fetch_pkg::vaddr_t      lookup_pc_i,
    input  fetch_pkg::bp_resolve_t update_i,
    output fetch_pkg::bht_pred_t   pred_o
);
    import fetch_pkg::*;

    logic [BHT_ENTRIES-1:0] valid_q;
    bht_cnt_e               cnt_q [BHT_ENTRIES];

    bht_idx_t lookup_idx;
    bht_idx_t upd_idx;
    bht_cnt_e lookup_cnt;
    bht_cnt_e upd_cnt;
    bht_cnt_e cnt_next;
    logic     upd_en;

    // ------------------------------
    // lookup
    // ------------------------------
    // word aligned pc, so skip the two low bits
    assign lookup_idx = lookup_pc_i[BHT_IDX_W+1:2];
    assign lookup_cnt = cnt_q[lookup_idx];

    assign pred_o.valid = valid_q[lookup_idx];
    assign pred_o.taken = lookup_cnt[1];

    // ------------------------------
    // update
    // ------------------------------
    assign upd_en  = update_i.valid & update_i.is_branch;
    assign upd_idx = update_i.pc[BHT_IDX_W+1:2];
    assign upd_cnt = cnt_q[upd_idx];

    always_comb begin
        cnt_next = upd_cnt;
        if (!valid_q[upd_idx]) begin
            // fresh entry starts weakly toward the outcome
            cnt_next = update_i.is_taken ? WEAK_T : WEAK_NT;
        end else begin
            // one step toward the outcome, saturating at both ends
            unique case (upd_cnt)
                STRONG_NT: cnt_next = update_i.is_taken ? WEAK_NT  : STRONG_NT;
                WEAK_NT:   cnt_next = update_i.is_taken ? WEAK_T   : STRONG_NT;
                WEAK_T:    cnt_next = update_i.is_taken ? STRONG_T : WEAK_NT;
                default:   cnt_next = update_i.is_taken ? STRONG_T : WEAK_T;
            endcase
        end
    end

    // valid bits, flush beats an update in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_bp_i) begin
            valid_q <= '0;
        end else if (upd_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // counters only mean something behind a valid bit
    always_ff @(posedge clk_i) begin
        if (upd_en) begin
            cnt_q[upd_idx] <= cnt_next;
        end
    end

    // a flush leaves the whole table invalid, even with an update alongside
    a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_bp_i |=> (valid_q == '0));

endmodule

// File: hdl/branch_predict.sv
`timescale 1ns/100ps

module branch_predict (
    input  logic                    f2_valid_i,
    input  fetch_pkg::vaddr_t       f2_addr_i,
    input  fetch_pkg::instr_t       instr_i,
    input  fetch_pkg::bht_pred_t    bht_pred_i,
    output logic                    predict_taken_o,
    output fetch_pkg::vaddr_t       predict_target_o,
    output fetch_pkg::fetch_entry_t entry_o
);
    import fetch_pkg::*;

    logic   is_branch;
    logic   is_jal;
    vaddr_t imm;
    logic   branch_taken;
    logic   taken;

    instr_scan i_instr_scan (
        .instr_i     ( instr_i   ),
        .is_branch_o ( is_branch ),
        .is_jal_o    ( is_jal    ),
        .imm_o       ( imm       )
    );

    // ------------------------------
    // taken decision
    // ------------------------------
    // dynamic when the table knows the branch
    // otherwise backward taken, forward not taken
    assign branch_taken = bht_pred_i.valid ? bht_pred_i.taken : imm[VLEN-1];

    // jal has a known target and always goes
    assign taken = is_jal | (is_branch & branch_taken);

    // nothing in f2 means nothing to redirect on
    assign predict_taken_o  = f2_valid_i & taken;
    assign predict_target_o = f2_addr_i + imm;

    // ------------------------------
    // queue entry
    // ------------------------------
    assign entry_o.addr       = f2_addr_i;
    assign entry_o.instr      = instr_i;
    assign entry_o.pred_taken = predict_taken_o;
    // not-taken entries carry the fall-through address
    assign entry_o.pred_target = predict_taken_o ? predict_target_o
                                                 : f2_addr_i + vaddr_t'(INSTR_BYTES);

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

    // ------------------------------
    // widths and constants
    // ------------------------------
    localparam int unsigned VLEN        = 32;
    localparam int unsigned ILEN        = 32;
    localparam logic [VLEN-1:0] BOOT_ADDR = 32'h0000_1000;
    localparam int unsigned INSTR_BYTES = 4;

    // history table, indexed by pc[5:2]
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = 4;

    // queue toward the back-end
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = 2;
    // count runs 0..QUEUE_DEPTH, so one bit wider than the pointers
    localparam int unsigned QUEUE_CNT_W = 3;

    // rv32i opcodes seen by the scanner
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [VLEN-1:0]      vaddr_t;
    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [BHT_IDX_W-1:0] bht_idx_t;

    // saturating counter, upper bit set means taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bht_cnt_e;

    // ------------------------------
    // port structs
    // ------------------------------
    typedef struct packed {
        logic   valid;
        vaddr_t addr;
    } imem_req_t;

    // resolved control flow from the back-end
    typedef struct packed {
        logic   valid;
        logic   is_branch;
        logic   is_taken;
        logic   is_mispredict;
        vaddr_t pc;
        vaddr_t target;
    } bp_resolve_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    typedef struct packed {
        vaddr_t addr;
        instr_t instr;
        logic   pred_taken;
        vaddr_t pred_target;
    } fetch_entry_t;

endpackage

// File: hdl/fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    wr_valid_i,
    input  logic                    kill_i,
    input  fetch_pkg::fetch_entry_t entry_i,
    output logic                    room_o,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);
    import fetch_pkg::*;

    fetch_entry_t           mem_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_CNT_W-1:0] count_q;
    logic [QUEUE_CNT_W-1:0] count_d;
    logic                   push;
    logic                   pop;

    // ------------------------------
    // handshakes
    // ------------------------------
    assign push = wr_valid_i & ~kill_i;
    assign pop  = fetch_entry_valid_o & fetch_entry_ready_i;

    // head of the buffer, held until the back-end takes it
    assign fetch_entry_valid_o = (count_q != '0);
    assign fetch_entry_o       = mem_q[rd_ptr_q];

    // two free slots: one for f2 now, one for the request behind it
    assign room_o = (count_q <= QUEUE_CNT_W'(QUEUE_DEPTH - 2));

    always_comb begin
        count_d = count_q;
        unique case ({push, pop})
            2'b10:   count_d = count_q + QUEUE_CNT_W'(1);
            2'b01:   count_d = count_q - QUEUE_CNT_W'(1);
            default: count_d = count_q;
        endcase
    end

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything fetched down the old path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + QUEUE_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + QUEUE_PTR_W'(1);
            end
            count_q <= count_d;
        end
    end

    // depth is a power of two so pointers wrap on their own
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // the room threshold in pc_gen must keep the in-flight entry from overflowing
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> (count_q < QUEUE_CNT_W'(QUEUE_DEPTH)));

endmodule

// File: hdl/frontend_top.sv
`timescale 1ns/100ps

module frontend_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    flush_bp_i,
    input  logic                    eret_i,
    input  logic                    ex_valid_i,
    input  logic                    set_pc_commit_i,
    input  fetch_pkg::bp_resolve_t  resolved_branch_i,
    input  fetch_pkg::vaddr_t       epc_i,
    input  fetch_pkg::vaddr_t       trap_vector_base_i,
    input  fetch_pkg::vaddr_t       pc_commit_i,
    output fetch_pkg::imem_req_t    imem_req_o,
    input  fetch_pkg::instr_t       imem_data_i,
    output fetch_pkg::fetch_entry_t fetch_entry_o,
    output logic                    fetch_entry_valid_o,
    input  logic                    fetch_entry_ready_i
);
    import fetch_pkg::*;

    // f2 stage
    logic         f2_valid;
    vaddr_t       f2_addr;
    // prediction
    bht_pred_t    bht_pred;
    logic         predict_taken;
    vaddr_t       predict_target;
    fetch_entry_t entry;
    // queue control
    logic         queue_room;
    logic         kill;

    pc_gen i_pc_gen (
        .clk_i              ( clk_i              ),
        .rst_ni             ( rst_ni             ),
        .queue_room_i       ( queue_room         ),
        .predict_taken_i    ( predict_taken      ),
        .predict_target_i   ( predict_target     ),
        .resolved_branch_i  ( resolved_branch_i  ),
        .eret_i             ( eret_i             ),
        .epc_i              ( epc_i              ),
        .ex_valid_i         ( ex_valid_i         ),
        .trap_vector_base_i ( trap_vector_base_i ),
        .set_pc_commit_i    ( set_pc_commit_i    ),
        .pc_commit_i        ( pc_commit_i        ),
        .flush_i            ( flush_i            ),
        .imem_req_o         ( imem_req_o         ),
        .f2_valid_o         ( f2_valid           ),
        .f2_addr_o          ( f2_addr            ),
        .kill_o             ( kill               )
    );

    // table is looked up with the address whose word arrives this cycle
    bht i_bht (
        .clk_i       ( clk_i             ),
        .rst_ni      ( rst_ni            ),
        .flush_bp_i  ( flush_bp_i        ),
        .lookup_pc_i ( f2_addr           ),
        .update_i    ( resolved_branch_i ),
        .pred_o      ( bht_pred          )
    );

    branch_predict i_branch_predict (
        .f2_valid_i       ( f2_valid       ),
        .f2_addr_i        ( f2_addr        ),
        .instr_i          ( imem_data_i    ),
        .bht_pred_i       ( bht_pred       ),
        .predict_taken_o  ( predict_taken  ),
        .predict_target_o ( predict_target ),
        .entry_o          ( entry          )
    );

    // every valid f2 word goes to the queue unless a redirect kills it
    fetch_queue i_fetch_queue (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .flush_i             ( flush_i             ),
        .wr_valid_i          ( f2_valid            ),
        .kill_i              ( kill                ),
        .entry_i             ( entry               ),
        .room_o              ( queue_room          ),
        .fetch_entry_o       ( fetch_entry_o       ),
        .fetch_entry_valid_o ( fetch_entry_valid_o ),
        .fetch_entry_ready_i ( fetch_entry_ready_i )
    );

endmodule

// File: hdl/instr_scan.sv
`timescale 1ns/100ps

module instr_scan (
    input  fetch_pkg::instr_t instr_i,
    output logic              is_branch_o,
    output logic              is_jal_o,
    output fetch_pkg::vaddr_t imm_o
);
    import fetch_pkg::*;

    logic [6:0] opcode;
    vaddr_t     imm_b;
    vaddr_t     imm_j;

    assign opcode = instr_i[6:0];

    // conditional branches only, jalr is left to the back-end
    assign is_branch_o = (opcode == OPCODE_BRANCH);
    assign is_jal_o    = (opcode == OPCODE_JAL);

    // b-type immediate
    // bit 0 is always zero, sign from instr[31]
    assign imm_b = {{(VLEN-12){instr_i[31]}},
                    instr_i[7],
                    instr_i[30:25],
                    instr_i[11:8],
                    1'b0};

    // j-type immediate, 21 bits before extension
    assign imm_j = {{(VLEN-20){instr_i[31]}},
                    instr_i[19:12],
                    instr_i[20],
                    instr_i[30:21],
                    1'b0};

    // pick the format that matches the opcode
    always_comb begin
        imm_o = '0;
        if (is_branch_o) begin
            imm_o = imm_b;
        end else if (is_jal_o) begin
            imm_o = imm_j;
        end
    end

endmodule

// File: hdl/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   queue_room_i,
    input  logic                   predict_taken_i,
    input  fetch_pkg::vaddr_t      predict_target_i,
    input  fetch_pkg::bp_resolve_t resolved_branch_i,
    input  logic                   eret_i,
    input  fetch_pkg::vaddr_t      epc_i,
    input  logic                   ex_valid_i,
    input  fetch_pkg::vaddr_t      trap_vector_base_i,
    input  logic                   set_pc_commit_i,
    input  fetch_pkg::vaddr_t      pc_commit_i,
    input  logic                   flush_i,
    output fetch_pkg::imem_req_t   imem_req_o,
    output logic                   f2_valid_o,
    output fetch_pkg::vaddr_t      f2_addr_o,
    output logic                   kill_o
);
    import fetch_pkg::*;

    vaddr_t pc_q;
    vaddr_t npc;
    vaddr_t f2_addr_q;
    logic   f2_valid_q;
    logic   req_valid;
    logic   is_mispredict;

    // ------------------------------
    // f1 request
    // ------------------------------
    // issue whenever the queue can still absorb the f2 entry
    assign req_valid       = queue_room_i;
    assign imem_req_o.valid = req_valid;
    assign imem_req_o.addr  = pc_q;

    assign is_mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;

    // any back-end redirect drops both the f1 request and the f2 entry
    assign kill_o = flush_i | is_mispredict | eret_i | ex_valid_i | set_pc_commit_i;

    // ------------------------------
    // next pc, lowest to highest
    // ------------------------------
    always_comb begin
        npc = pc_q;
        if (req_valid) begin
            npc = pc_q + vaddr_t'(INSTR_BYTES);
        end
        // taken in f2 throws away the sequential request behind it
        if (predict_taken_i) begin
            npc = predict_target_i;
        end
        if (is_mispredict) begin
            npc = resolved_branch_i.target;
        end
        if (eret_i) begin
            npc = epc_i;
        end
        if (ex_valid_i) begin
            npc = trap_vector_base_i;
        end
        // restart after the committing instruction
        if (set_pc_commit_i) begin
            npc = pc_commit_i + vaddr_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q       <= BOOT_ADDR;
            f2_valid_q <= 1'b0;
        end else begin
            pc_q       <= npc;
            f2_valid_q <= req_valid & ~kill_o & ~predict_taken_i;
        end
    end

    // address of the request now in flight to memory
    always_ff @(posedge clk_i) begin
        if (req_valid) begin
            f2_addr_q <= pc_q;
        end
    end

    assign f2_valid_o = f2_valid_q;
    assign f2_addr_o  = f2_addr_q;

    // targets from predictor and back-end must keep fetch word aligned
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pc_q[1:0] == 2'b00);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fetch frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_frontend -f filelist.f -o sim_frontend; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_frontend)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// File: verif/imem_model.sv
`timescale 1ns/100ps

module imem_model (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  fetch_pkg::imem_req_t req_i,
    output fetch_pkg::instr_t    data_o
);
    import fetch_pkg::*;

    // sparse word store, keyed by byte address
    instr_t mem [vaddr_t];

    // unwritten words are plain alu ops
    // every address bit feeds the pattern
    function automatic instr_t fill_word(input vaddr_t addr);
        return {addr[31:7] ^ addr[24:0], 7'b0010011};
    endfunction

    function automatic instr_t read_word(input vaddr_t addr);
        if (mem.exists(addr) != 0) begin
            return mem[addr];
        end
        return fill_word(addr);
    endfunction

    // preload port for the test tasks
    task automatic write_word(input vaddr_t addr, input instr_t data);
        mem[addr] = data;
    endtask

    // ------------------------------
    // one cycle read latency
    // ------------------------------
    // no valid on the answer, the frontend knows what it asked for
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_o <= '0;
        end else if (req_i.valid) begin
            data_o <= read_word(req_i.addr);
        end
    end

endmodule

// File: verif/tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend;
    import fetch_pkg::*;

    // entries checked per test set the run limit
    localparam int N_SEQ       = 12;
    localparam int N_STATIC    = 9;
    localparam int N_HISTORY   = 4;
    localparam int N_REDIRECT  = 8;
    localparam int N_BACKPR    = 24;
    localparam int CYCLE_LIMIT =
        (N_SEQ + N_STATIC + N_HISTORY + N_REDIRECT + N_BACKPR) * 8 + 500;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         flush;
    logic         flush_bp;
    logic         eret;
    logic         ex_valid;
    logic         set_pc_commit;
    bp_resolve_t  resolved_branch;
    vaddr_t       epc;
    vaddr_t       trap_base;
    vaddr_t       pc_commit;
    imem_req_t    imem_req;
    instr_t       imem_data;
    fetch_entry_t fetch_entry;
    logic         fetch_entry_valid;
    logic         fetch_entry_ready;

    // entries taken by the back-end, in order
    fetch_entry_t got [$];
    // words stored by the tests serve as expected instructions
    instr_t       shadow [vaddr_t];
    vaddr_t       mis_target;
    string        cur_test;
    int           err_cnt;
    int           check_cnt;
    int           test_cnt;
    int           test_err_base;
    int           cycle_cnt = 0;

    // period 8 ns
    always #4 clk_i = ~clk_i;

    frontend_top dut (
        .clk_i               ( clk_i             ),
        .rst_ni              ( rst_ni            ),
        .flush_i             ( flush             ),
        .flush_bp_i          ( flush_bp          ),
        .eret_i              ( eret              ),
        .ex_valid_i          ( ex_valid          ),
        .set_pc_commit_i     ( set_pc_commit     ),
        .resolved_branch_i   ( resolved_branch   ),
        .epc_i               ( epc               ),
        .trap_vector_base_i  ( trap_base         ),
        .pc_commit_i         ( pc_commit         ),
        .imem_req_o          ( imem_req          ),
        .imem_data_i         ( imem_data         ),
        .fetch_entry_o       ( fetch_entry       ),
        .fetch_entry_valid_o ( fetch_entry_valid ),
        .fetch_entry_ready_i ( fetch_entry_ready )
    );

    imem_model i_imem_model (
        .clk_i  ( clk_i     ),
        .rst_ni ( rst_ni    ),
        .req_i  ( imem_req  ),
        .data_o ( imem_data )
    );

    // hard stop if the stream never completes
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: %s still waiting for entries after %0d cycles",
                     cur_test, cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------
    // instruction encoders
    // ------------------------------
    // addi x1, x1 with the word index as immediate
    function automatic instr_t alu_word(input vaddr_t a);
        return {a[13:2], 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    // beq x0, x0, off
    function automatic instr_t beq_word(input vaddr_t off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // jal x0, off
    function automatic instr_t jal_word(input vaddr_t off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    task automatic load_word(input vaddr_t a, input instr_t w);
        shadow[a] = w;
        i_imem_model.write_word(a, w);
    endtask

    task automatic load_alu_run(input vaddr_t base, input int n);
        int i;
        for (i = 0; i < n; i++) begin
            load_word(base + vaddr_t'(4 * i), alu_word(base + vaddr_t'(4 * i)));
        end
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic compare_addr(input string what, input vaddr_t exp, input vaddr_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_instr(input string what, input instr_t exp, input instr_t act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_entry(input string what, input fetch_entry_t e,
                               input vaddr_t exp_addr, input logic exp_pt);
        compare_addr({what, " addr"}, exp_addr, e.addr);
        compare_instr({what, " instr"}, shadow[exp_addr], e.instr);
        compare_flag({what, " pred_taken"}, exp_pt, e.pred_taken);
    endtask

    // ------------------------------
    // cycle helpers
    // ------------------------------
    // called on a falling edge once this cycle's inputs are driven
    task automatic next_cycle();
        if (fetch_entry_valid && fetch_entry_ready) begin
            got.push_back(fetch_entry);
        end
        @(negedge clk_i);
    endtask

    task automatic collect(input int n);
        while (got.size() < n) begin
            next_cycle();
        end
    endtask

    // srcs is {mispredict, eret, exception, commit} and flush is always set
    task automatic redirect_pulse(input logic [3:0] srcs);
        flush = 1'b1;
        resolved_branch = '0;
        resolved_branch.valid = srcs[3];
        resolved_branch.is_mispredict = srcs[3];
        resolved_branch.target = mis_target;
        eret = srcs[2];
        ex_valid = srcs[1];
        set_pc_commit = srcs[0];
        next_cycle();
        flush = 1'b0;
        resolved_branch = '0;
        eret = 1'b0;
        ex_valid = 1'b0;
        set_pc_commit = 1'b0;
        // whatever the back-end took before the redirect is old path
        got.delete();
    endtask

    // commit restarts at pc_commit + 4
    task automatic restart_at(input vaddr_t a);
        pc_commit = a - 32'd4;
        redirect_pulse(4'b0001);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_base = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == test_err_base) begin
            $display("%s: pass", cur_test);
        end else begin
            $display("%s: FAIL with %0d errors", cur_test, err_cnt - test_err_base);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic sequential_fetch();
        int i;
        start_test("sequential_fetch");
        load_alu_run(BOOT_ADDR, N_SEQ + 4);
        collect(N_SEQ);
        for (i = 0; i < N_SEQ; i++) begin
            check_entry($sformatf("entry %0d", i), got[i], BOOT_ADDR + vaddr_t'(4 * i), 1'b0);
        end
        end_test();
    endtask

    task automatic static_prediction();
        vaddr_t exp_addr [N_STATIC];
        logic   exp_pt [N_STATIC];
        vaddr_t exp_tgt [N_STATIC];
        int     i;
        start_test("static_prediction");
        load_word(32'h0000_2000, alu_word(32'h0000_2000));
        // forward branch falls through
        load_word(32'h0000_2004, beq_word(32'd16));
        load_word(32'h0000_2008, alu_word(32'h0000_2008));
        load_word(32'h0000_200c, jal_word(32'h0000_0020));
        load_word(32'h0000_2024, alu_word(32'h0000_2024));
        load_word(32'h0000_2028, alu_word(32'h0000_2028));
        // backward branch closes a three word loop
        load_word(32'h0000_202c, beq_word(32'hffff_fff8));
        exp_addr = '{32'h2000, 32'h2004, 32'h2008, 32'h200c, 32'h202c,
                     32'h2024, 32'h2028, 32'h202c, 32'h2024};
        exp_pt = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
        // address plus immediate of the taken entries
        exp_tgt = '{32'h0, 32'h0, 32'h0, 32'h202c, 32'h2024,
                    32'h0, 32'h0, 32'h2024, 32'h0};
        restart_at(32'h0000_2000);
        collect(N_STATIC);
        for (i = 0; i < N_STATIC; i++) begin
            check_entry($sformatf("entry %0d", i), got[i], exp_addr[i], exp_pt[i]);
            if (exp_pt[i]) begin
                compare_addr($sformatf("entry %0d pred_target", i), exp_tgt[i],
                             got[i].pred_target);
            end
        end
        end_test();
    endtask

    task automatic history_learning();
        start_test("history_learning");
        load_word(32'h0000_3010, beq_word(32'd32));
        load_word(32'h0000_3014, alu_word(32'h0000_3014));
        load_word(32'h0000_3030, alu_word(32'h0000_3030));
        // two taken outcomes move the counter to weak then strong taken
        resolved_branch = '0;
        resolved_branch.valid = 1'b1;
        resolved_branch.is_branch = 1'b1;
        resolved_branch.is_taken = 1'b1;
        resolved_branch.pc = 32'h0000_3010;
        resolved_branch.target = 32'h0000_3030;
        next_cycle();
        next_cycle();
        resolved_branch = '0;
        mis_target = 32'h0000_3010;
        redirect_pulse(4'b1000);
        collect(2);
        check_entry("learned branch", got[0], 32'h0000_3010, 1'b1);
        compare_addr("learned branch pred_target", 32'h0000_3030, got[0].pred_target);
        check_entry("learned target", got[1], 32'h0000_3030, 1'b0);
        // with the table cleared the forward branch falls through again
        flush_bp = 1'b1;
        next_cycle();
        flush_bp = 1'b0;
        redirect_pulse(4'b1000);
        collect(2);
        check_entry("flushed branch", got[0], 32'h0000_3010, 1'b0);
        check_entry("flushed fall-through", got[1], 32'h0000_3014, 1'b0);
        end_test();
    endtask

    task automatic redirect_case(input logic [3:0] srcs, input vaddr_t exp_addr);
        redirect_pulse(srcs);
        collect(2);
        check_entry($sformatf("sources %b first", srcs), got[0], exp_addr, 1'b0);
        check_entry($sformatf("sources %b second", srcs), got[1], exp_addr + 32'd4, 1'b0);
    endtask

    task automatic redirect_precedence();
        start_test("redirect_precedence");
        load_alu_run(32'h0000_4000, 2);
        load_alu_run(32'h0000_4100, 2);
        load_alu_run(32'h0000_4200, 2);
        load_alu_run(32'h0000_4300, 2);
        mis_target = 32'h0000_4000;
        epc = 32'h0000_4100;
        trap_base = 32'h0000_4200;
        pc_commit = 32'h0000_42fc;
        // eret over mispredict, trap over eret, commit over all
        redirect_case(4'b1100, 32'h0000_4100);
        redirect_case(4'b1110, 32'h0000_4200);
        redirect_case(4'b1111, 32'h0000_4300);
        redirect_case(4'b1000, 32'h0000_4000);
        end_test();
    endtask

    task automatic back_pressure();
        int   stretch;
        logic level;
        int   i;
        start_test("back_pressure");
        load_alu_run(32'h0000_5000, N_BACKPR + 8);
        restart_at(32'h0000_5000);
        stretch = 0;
        level = 1'b1;
        while (got.size() < N_BACKPR) begin
            if (stretch == 0) begin
                level = 1'($urandom_range(0, 1));
                stretch = int'($urandom_range(1, 6));
            end
            stretch--;
            fetch_entry_ready = level;
            // near full only the f2 entry in flight may still arrive
            if (dut.i_fetch_queue.count_q >= QUEUE_CNT_W'(QUEUE_DEPTH - 1)) begin
                compare_flag("request at high occupancy", 1'b0, imem_req.valid);
            end
            next_cycle();
        end
        fetch_entry_ready = 1'b1;
        for (i = 0; i < N_BACKPR; i++) begin
            check_entry($sformatf("entry %0d", i), got[i],
                        32'h0000_5000 + vaddr_t'(4 * i), 1'b0);
        end
        end_test();
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        void'($urandom(32'hcae7));
        rst_ni = 1'b0;
        flush = 1'b0;
        flush_bp = 1'b0;
        eret = 1'b0;
        ex_valid = 1'b0;
        set_pc_commit = 1'b0;
        resolved_branch = '0;
        epc = '0;
        trap_base = '0;
        pc_commit = '0;
        mis_target = '0;
        fetch_entry_ready = 1'b1;
        err_cnt = 0;
        check_cnt = 0;
        test_cnt = 0;
        cur_test = "reset";
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        sequential_fetch();
        static_prediction();
        history_learning();
        redirect_precedence();
        back_pressure();
        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
